/* include/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath and address widths
`define CPU_DATA_W    32
`define CPU_ADDR_W    32

// Register index, 32 architectural registers
`define CPU_REG_W     5

// Cycles from MUL issue to writeback
`define CPU_MUL_DEPTH 3

// First fetch address
`define CPU_RESET_PC  32'h0000_0000

`endif

/* verilog/cpu_pkg.sv */
`include "cpu_settings.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0] data_t;
  typedef logic [`CPU_ADDR_W-1:0] addr_t;
  typedef logic [`CPU_REG_W-1:0]  reg_idx_t;
  typedef logic [31:0]            instr_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011
  } opcode_e;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL
  } alu_op_e;

  typedef struct packed {
    logic     valid;
    alu_op_e  op;
    data_t    a;
    data_t    b;
    reg_idx_t rd;
  } alu_req_t;

  typedef struct packed {
    logic     valid;
    data_t    a;
    data_t    b;
    reg_idx_t rd;
  } mul_req_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    data_t    data;
  } lane_res_t;

  typedef struct packed {
    logic     en;
    reg_idx_t idx;
    data_t    data;
  } reg_wr_t;

endpackage

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps

`include "cpu_settings.svh"

module fetch_stage (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            stall_i,
  input  logic            instr_valid_i,
  input  cpu_pkg::instr_t instr_i,
  output logic            rd_req_valid_o,
  output cpu_pkg::addr_t  req_address_o,
  output logic            dec_valid_o,
  output cpu_pkg::instr_t dec_instr_o
);

  import cpu_pkg::*;

  logic   run_q;
  addr_t  pc_q;
  logic   dec_valid_q;
  instr_t dec_instr_q;
  logic   hold_valid_q;
  instr_t hold_instr_q;
  logic   advance;
  logic   to_hold;

  // Decode word is free or gets consumed this cycle
  assign advance = !dec_valid_q || !stall_i;

  // Response arrives while decode is blocked
  assign to_hold = instr_valid_i && !advance;

  // One response can still be in flight, so leave room for it
  assign rd_req_valid_o = run_q && !hold_valid_q && !to_hold;
  assign req_address_o  = pc_q;
  assign dec_valid_o    = dec_valid_q;
  assign dec_instr_o    = dec_instr_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      run_q        <= 1'b0;
      pc_q         <= `CPU_RESET_PC;
      dec_valid_q  <= 1'b0;
      hold_valid_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (rd_req_valid_o) begin
        pc_q <= pc_q + addr_t'(4);
      end
      if (advance) begin
        // Holding register is older than any new response
        dec_valid_q  <= hold_valid_q || instr_valid_i;
        hold_valid_q <= 1'b0;
      end else if (instr_valid_i) begin
        hold_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      dec_instr_q <= hold_valid_q ? hold_instr_q : instr_i;
    end
    if (to_hold) begin
      hold_instr_q <= instr_i;
    end
  end

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               valid_i,
  input  cpu_pkg::instr_t    instr_i,
  input  cpu_pkg::data_t     rs1_data_i,
  input  cpu_pkg::data_t     rs2_data_i,
  input  cpu_pkg::lane_res_t mul_s1_i,
  input  cpu_pkg::lane_res_t mul_s2_i,
  output cpu_pkg::reg_idx_t  rs1_o,
  output cpu_pkg::reg_idx_t  rs2_o,
  output logic               stall_o,
  output cpu_pkg::alu_req_t  alu_req_o,
  output cpu_pkg::mul_req_t  mul_req_o
);

  import cpu_pkg::*;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;
  localparam logic [6:0] F7_MUL  = 7'b0000001;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  reg_idx_t   rd;
  data_t      imm;
  alu_op_e    op;
  logic       is_alu;
  logic       is_mul;
  logic       uses_rs2;
  logic       raw_rs1;
  logic       raw_rs2;
  logic       issue;

  function automatic logic mul_hit(lane_res_t stage, reg_idx_t src);
    return stage.valid && (stage.rd == src) && (src != '0);
  endfunction

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];
  assign funct7 = instr_i[31:25];
  assign imm    = data_t'($signed(instr_i[31:20]));

  // Lane steering, anything unmatched retires as a no-op
  always_comb begin
    is_alu = 1'b0;
    is_mul = 1'b0;
    op     = ADD;
    if (opcode == OP_IMM) begin
      is_alu = (funct3 == 3'b000);
    end else if (opcode == OP) begin
      if (funct7 == F7_MUL) begin
        is_mul = (funct3 == 3'b000);
      end else if (funct7 == F7_ALT) begin
        is_alu = (funct3 == 3'b000);
        op     = SUB;
      end else if (funct7 == F7_BASE) begin
        is_alu = 1'b1;
        case (funct3)
          3'b000:  op = ADD;
          3'b001:  op = SLL;
          3'b100:  op = XOR;
          3'b101:  op = SRL;
          3'b110:  op = OR;
          3'b111:  op = AND;
          default: is_alu = 1'b0;
        endcase
      end
    end
  end

  assign uses_rs2 = (opcode == OP);

  // Stage 3 and ALU results reach us through the register file bypass
  assign raw_rs1 = mul_hit(mul_s1_i, rs1_o) || mul_hit(mul_s2_i, rs1_o);
  assign raw_rs2 = uses_rs2 && (mul_hit(mul_s1_i, rs2_o) || mul_hit(mul_s2_i, rs2_o));

  // ALU issue next to MUL stage 2 would collide in writeback
  assign stall_o = valid_i && (is_alu || is_mul) &&
                   (raw_rs1 || raw_rs2 || (is_alu && mul_s2_i.valid));

  assign issue = valid_i && !stall_o;

  always_comb begin
    alu_req_o.valid = issue && is_alu;
    alu_req_o.op    = op;
    alu_req_o.a     = rs1_data_i;
    alu_req_o.b     = (opcode == OP_IMM) ? imm : rs2_data_i;
    alu_req_o.rd    = rd;

    mul_req_o.valid = issue && is_mul;
    mul_req_o.a     = rs1_data_i;
    mul_req_o.b     = rs2_data_i;
    mul_req_o.rd    = rd;
  end

endmodule

/* verilog/rbank.sv */
`timescale 1ns/1ps

module rbank (
  input  logic              clk_i,
  input  logic              rst_i,
  input  cpu_pkg::reg_wr_t  wr_i,
  input  cpu_pkg::reg_idx_t rd_a_i,
  input  cpu_pkg::reg_idx_t rd_b_i,
  input  cpu_pkg::reg_idx_t dbg_idx_i,
  output cpu_pkg::data_t    rd_a_data_o,
  output cpu_pkg::data_t    rd_b_data_o,
  output cpu_pkg::data_t    dbg_data_o
);

  import cpu_pkg::*;

  localparam int NREGS = 2 ** $bits(reg_idx_t);

  data_t regs_q [NREGS];

  // Same-cycle write is returned to the reader
  function automatic data_t read_port(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (wr_i.en && (wr_i.idx == idx)) begin
      return wr_i.data;
    end
    return regs_q[idx];
  endfunction

  always_comb begin
    rd_a_data_o = read_port(rd_a_i);
    rd_b_data_o = read_port(rd_b_i);
  end

  assign dbg_data_o = regs_q[dbg_idx_i];

  // x0 is never written
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.en && (wr_i.idx != '0)) begin
      regs_q[wr_i.idx] <= wr_i.data;
    end
  end

endmodule

/* verilog/alu_stage.sv */
`timescale 1ns/1ps

`include "cpu_settings.svh"

module alu_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  cpu_pkg::alu_req_t  req_i,
  output cpu_pkg::lane_res_t res_o
);

  import cpu_pkg::*;

  localparam int SHAMT_W = $clog2(`CPU_DATA_W);

  logic [SHAMT_W-1:0] shamt;
  data_t              result;
  logic               res_valid_q;
  reg_idx_t           res_rd_q;
  data_t              res_data_q;

  assign shamt = req_i.b[SHAMT_W-1:0];

  always_comb begin
    case (req_i.op)
      ADD:     result = req_i.a + req_i.b;
      SUB:     result = req_i.a - req_i.b;
      AND:     result = req_i.a & req_i.b;
      OR:      result = req_i.a | req_i.b;
      XOR:     result = req_i.a ^ req_i.b;
      SLL:     result = req_i.a << shamt;
      SRL:     result = req_i.a >> shamt;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    res_rd_q   <= req_i.rd;
    res_data_q <= result;
  end

  always_comb begin
    res_o.valid = res_valid_q;
    res_o.rd    = res_rd_q;
    res_o.data  = res_data_q;
  end

endmodule

/* verilog/mul_stages.sv */
`timescale 1ns/1ps

`include "cpu_settings.svh"

module mul_stages (
  input  logic               clk_i,
  input  logic               rst_i,
  input  cpu_pkg::mul_req_t  req_i,
  output cpu_pkg::lane_res_t s1_o,
  output cpu_pkg::lane_res_t s2_o,
  output cpu_pkg::lane_res_t res_o
);

  import cpu_pkg::*;

  localparam int HALF_W = `CPU_DATA_W / 2;
  localparam int DEPTH  = `CPU_MUL_DEPTH;

  // Destination tags travel beside the data
  logic [DEPTH-1:0]  vld_q;
  reg_idx_t          rd_q [DEPTH];

  logic [HALF_W-1:0] a_lo_q;
  logic [HALF_W-1:0] a_hi_q;
  logic [HALF_W-1:0] b_lo_q;
  logic [HALF_W-1:0] b_hi_q;
  data_t             ll_q;
  logic [HALF_W-1:0] lh_q;
  logic [HALF_W-1:0] hl_q;
  data_t             prod_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[DEPTH-2:0], req_i.valid};
    end
  end

  always_ff @(posedge clk_i) begin
    rd_q[0] <= req_i.rd;
    for (int i = 1; i < DEPTH; i++) begin
      rd_q[i] <= rd_q[i-1];
    end

    a_lo_q <= req_i.a[HALF_W-1:0];
    a_hi_q <= req_i.a[`CPU_DATA_W-1:HALF_W];
    b_lo_q <= req_i.b[HALF_W-1:0];
    b_hi_q <= req_i.b[`CPU_DATA_W-1:HALF_W];

    // Only the low half of the cross terms reaches the low word
    ll_q <= data_t'(a_lo_q) * data_t'(b_lo_q);
    lh_q <= a_lo_q * b_hi_q;
    hl_q <= a_hi_q * b_lo_q;

    prod_q <= ll_q + {lh_q + hl_q, {HALF_W{1'b0}}};
  end

  always_comb begin
    s1_o       = '0;
    s1_o.valid = vld_q[0];
    s1_o.rd    = rd_q[0];

    s2_o       = '0;
    s2_o.valid = vld_q[1];
    s2_o.rd    = rd_q[1];

    res_o.valid = vld_q[DEPTH-1];
    res_o.rd    = rd_q[DEPTH-1];
    res_o.data  = prod_q;
  end

endmodule

/* verilog/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  cpu_pkg::lane_res_t alu_res_i,
  input  cpu_pkg::lane_res_t mul_res_i,
  output cpu_pkg::reg_wr_t   wr_o
);

  import cpu_pkg::*;

  lane_res_t sel;

  // Decode never lets both lanes finish in the same cycle
  assign sel = mul_res_i.valid ? mul_res_i : alu_res_i;

  always_comb begin
    wr_o.en   = sel.valid && (sel.rd != '0);
    wr_o.idx  = sel.rd;
    wr_o.data = sel.data;
  end

endmodule

/* verilog/cpu.sv */
`timescale 1ns/1ps

module cpu (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              mem_data_valid_i,
  input  cpu_pkg::instr_t   mem_data_i,
  output logic              rd_req_valid_o,
  output cpu_pkg::addr_t    req_address_o,
  input  cpu_pkg::reg_idx_t dbg_idx_i,
  output cpu_pkg::data_t    dbg_data_o,
  output logic              commit_valid_o,
  output cpu_pkg::reg_idx_t commit_rd_o,
  output cpu_pkg::data_t    commit_data_o
);

  import cpu_pkg::*;

  // Fetch to decode
  logic      dec_valid;
  instr_t    dec_instr;
  logic      dec_stall;

  // Register file reads
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  data_t     rs1_data;
  data_t     rs2_data;

  // Lanes
  alu_req_t  alu_req;
  mul_req_t  mul_req;
  lane_res_t alu_res;
  lane_res_t mul_s1;
  lane_res_t mul_s2;
  lane_res_t mul_res;

  reg_wr_t   wb_wr;

  fetch_stage fetch_stage (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .stall_i        (dec_stall),
    .instr_valid_i  (mem_data_valid_i),
    .instr_i        (mem_data_i),
    .rd_req_valid_o (rd_req_valid_o),
    .req_address_o  (req_address_o),
    .dec_valid_o    (dec_valid),
    .dec_instr_o    (dec_instr)
  );

  decode_stage decode_stage (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .valid_i    (dec_valid),
    .instr_i    (dec_instr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .mul_s1_i   (mul_s1),
    .mul_s2_i   (mul_s2),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .stall_o    (dec_stall),
    .alu_req_o  (alu_req),
    .mul_req_o  (mul_req)
  );

  rbank rbank (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wr_i        (wb_wr),
    .rd_a_i      (rs1),
    .rd_b_i      (rs2),
    .dbg_idx_i   (dbg_idx_i),
    .rd_a_data_o (rs1_data),
    .rd_b_data_o (rs2_data),
    .dbg_data_o  (dbg_data_o)
  );

  alu_stage alu_stage (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (alu_req),
    .res_o (alu_res)
  );

  mul_stages mul_stages (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (mul_req),
    .s1_o  (mul_s1),
    .s2_o  (mul_s2),
    .res_o (mul_res)
  );

  wb_stage wb_stage (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .alu_res_i (alu_res),
    .mul_res_i (mul_res),
    .wr_o      (wb_wr)
  );

  // Commit port mirrors the register write
  assign commit_valid_o = wb_wr.en;
  assign commit_rd_o    = wb_wr.idx;
  assign commit_data_o  = wb_wr.data;

endmodule

/* bench/cpu_tb.sv */
`timescale 1ns/1ps

`include "cpu_settings.svh"

module cpu_tb;

  import cpu_pkg::*;

  localparam int     NPROG    = 32;
  localparam int     NREGS    = 32;
  localparam int     TIMEOUT  = 4 * NPROG + 50;
  localparam instr_t NOP_WORD = 32'h0000_0013;

  typedef enum logic [3:0] {
    K_ADDI, K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLL, K_SRL, K_MUL, K_BAD
  } kind_e;

  typedef struct packed {
    kind_e    kind;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
  } tmpl_t;

  typedef struct packed {
    instr_t   word;
    logic     commits;
    reg_idx_t rd;
    data_t    value;
  } entry_t;

  // kind, rd, rs1, rs2
  localparam logic [18:0] PROG [NPROG] = '{
    {K_ADDI, 5'd1,  5'd0,  5'd0},
    {K_ADDI, 5'd2,  5'd0,  5'd0},
    {K_ADDI, 5'd3,  5'd1,  5'd0},
    {K_ADD,  5'd4,  5'd1,  5'd2},
    {K_SUB,  5'd5,  5'd0,  5'd3},
    {K_AND,  5'd6,  5'd4,  5'd5},
    {K_OR,   5'd7,  5'd5,  5'd2},
    {K_XOR,  5'd8,  5'd7,  5'd6},
    {K_SLL,  5'd9,  5'd5,  5'd2},
    {K_SRL,  5'd10, 5'd9,  5'd1},
    {K_MUL,  5'd11, 5'd5,  5'd4},
    {K_ADD,  5'd12, 5'd11, 5'd1},
    {K_MUL,  5'd13, 5'd9,  5'd9},
    {K_MUL,  5'd14, 5'd13, 5'd5},
    {K_MUL,  5'd15, 5'd7,  5'd8},
    {K_ADDI, 5'd16, 5'd0,  5'd0},
    {K_SUB,  5'd17, 5'd14, 5'd15},
    {K_ADD,  5'd0,  5'd1,  5'd2},
    {K_ADDI, 5'd0,  5'd3,  5'd0},
    {K_BAD,  5'd27, 5'd0,  5'd0},
    {K_MUL,  5'd0,  5'd4,  5'd5},
    {K_XOR,  5'd18, 5'd0,  5'd11},
    {K_SLL,  5'd19, 5'd1,  5'd3},
    {K_SRL,  5'd20, 5'd5,  5'd4},
    {K_ADDI, 5'd1,  5'd1,  5'd0},
    {K_MUL,  5'd21, 5'd1,  5'd20},
    {K_MUL,  5'd1,  5'd21, 5'd2},
    {K_ADD,  5'd22, 5'd1,  5'd17},
    {K_OR,   5'd23, 5'd22, 5'd0},
    {K_AND,  5'd24, 5'd23, 5'd9},
    {K_ADDI, 5'd25, 5'd24, 5'd0},
    {K_SUB,  5'd26, 5'd25, 5'd1}
  };

  logic     clk_i = 1'b0;
  logic     rst_i;
  logic     mem_data_valid_i;
  instr_t   mem_data_i;
  logic     rd_req_valid_o;
  addr_t    req_address_o;
  reg_idx_t dbg_idx_i;
  data_t    dbg_data_o;
  logic     commit_valid_o;
  reg_idx_t commit_rd_o;
  data_t    commit_data_o;

  entry_t      prog_tab [NPROG];
  int          match_cnt [NPROG];
  data_t       model_regs [NREGS];
  logic [15:0] lfsr_q;
  int          value_errors;
  int          other_errors;
  int          cycle_count;
  logic        req_pending;
  addr_t       req_addr;
  addr_t       next_addr;
  logic        first_req_seen;

  cpu dut_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .mem_data_valid_i (mem_data_valid_i),
    .mem_data_i       (mem_data_i),
    .rd_req_valid_o   (rd_req_valid_o),
    .req_address_o    (req_address_o),
    .dbg_idx_i        (dbg_idx_i),
    .dbg_data_o       (dbg_data_o),
    .commit_valid_o   (commit_valid_o),
    .commit_rd_o      (commit_rd_o),
    .commit_data_o    (commit_data_o)
  );

  initial begin
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // {funct7, funct3} of the register forms
  function automatic logic [9:0] funct_bits(kind_e k);
    case (k)
      K_SUB:   return {7'h20, 3'b000};
      K_AND:   return {7'h00, 3'b111};
      K_OR:    return {7'h00, 3'b110};
      K_XOR:   return {7'h00, 3'b100};
      K_SLL:   return {7'h00, 3'b001};
      K_SRL:   return {7'h00, 3'b101};
      K_MUL:   return {7'h01, 3'b000};
      default: return {7'h00, 3'b000};
    endcase
  endfunction

  function automatic instr_t enc_r(logic [9:0] f, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {f[9:3], rs2, rs1, f[2:0], rd, 7'b0110011};
  endfunction

  function automatic instr_t enc_i(logic [11:0] imm, reg_idx_t rd, reg_idx_t rs1);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic data_t model_result(kind_e k, data_t a, data_t b);
    case (k)
      K_ADD, K_ADDI: return a + b;
      K_SUB:         return a - b;
      K_AND:         return a & b;
      K_OR:          return a | b;
      K_XOR:         return a ^ b;
      K_SLL:         return a << b[4:0];
      K_SRL:         return a >> b[4:0];
      K_MUL:         return a * b;
      default:       return '0;
    endcase
  endfunction

  task automatic build_program();
    tmpl_t       t;
    logic [11:0] imm;
    data_t       a;
    data_t       b;
    data_t       r;
    instr_t      word;
    logic        writes;
    lfsr_q = 16'd39;
    for (int i = 0; i < NREGS; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < NPROG; i++) begin
      t      = tmpl_t'(PROG[i]);
      imm    = '0;
      a      = model_regs[t.rs1];
      b      = model_regs[t.rs2];
      writes = (t.kind != K_BAD) && (t.rd != '0);
      if (t.kind == K_ADDI) begin
        imm  = 12'(take_bits(12));
        b    = {{20{imm[11]}}, imm};
        word = enc_i(imm, t.rd, t.rs1);
      end else if (t.kind == K_BAD) begin
        word = {20'h0, t.rd, 7'h7F};
      end else begin
        word = enc_r(funct_bits(t.kind), t.rd, t.rs1, t.rs2);
      end
      r = model_result(t.kind, a, b);
      if (writes) begin
        model_regs[t.rd] = r;
      end
      prog_tab[i]  = {word, writes, t.rd, r};
      match_cnt[i] = 0;
    end
  endtask

  function automatic instr_t word_at(addr_t a);
    int idx;
    idx = int'(a >> 2);
    if (a < addr_t'(4 * NPROG)) begin
      return prog_tab[idx].word;
    end
    return NOP_WORD;
  endfunction

  function automatic int unmatched_count();
    int n;
    n = 0;
    for (int i = 0; i < NPROG; i++) begin
      if (prog_tab[i].commits && match_cnt[i] == 0) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got x%0d expected x%0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic report_error(string msg);
    $display("ERROR at %0t: %s", $time, msg);
    other_errors++;
  endtask

  // Commits may come out of program order
  task automatic match_commit(reg_idx_t rd, data_t data);
    int hit;
    int dup;
    int same;
    int any;
    int pick;
    hit  = -1;
    dup  = -1;
    same = -1;
    any  = -1;
    for (int i = 0; i < NPROG; i++) begin
      if (prog_tab[i].commits && match_cnt[i] == 0) begin
        if (any < 0) any = i;
        if (prog_tab[i].rd == rd && same < 0) same = i;
        if (prog_tab[i].rd == rd && prog_tab[i].value == data && hit < 0) hit = i;
      end else if (prog_tab[i].commits && prog_tab[i].rd == rd &&
                   prog_tab[i].value == data && dup < 0) begin
        dup = i;
      end
    end
    if (rd == '0) begin
      report_error("commit to x0 was not suppressed");
    end else if (hit >= 0) begin
      match_cnt[hit]++;
    end else if (dup >= 0) begin
      // Repeated commit of an entry already matched
      match_cnt[dup]++;
    end else if (any >= 0) begin
      pick = (same >= 0) ? same : any;
      check_reg("commit_rd_o", rd, prog_tab[pick].rd);
      check_data("commit_data_o", data, prog_tab[pick].value);
    end else begin
      report_error($sformatf("extra commit to x%0d with %h", rd, data));
    end
  endtask

  // Monitor samples mid-cycle
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (rd_req_valid_o !== 1'b0) begin
        report_error("instruction request raised during reset");
      end
      if (commit_valid_o !== 1'b0) begin
        report_error("commit raised during reset");
      end
    end else begin
      if (!first_req_seen && commit_valid_o !== 1'b0) begin
        report_error("commit seen before the first instruction request");
      end
      if (rd_req_valid_o) begin
        check_addr("req_address_o", req_address_o, next_addr);
        next_addr      = next_addr + addr_t'(4);
        first_req_seen = 1'b1;
      end
      if (commit_valid_o) begin
        match_commit(commit_rd_o, commit_data_o);
      end
    end
    req_pending = rst_i && rd_req_valid_o;
    req_addr    = req_address_o;
  end

  // Memory answers one cycle after the request
  always @(posedge clk_i) begin
    #1;
    mem_data_valid_i = req_pending;
    mem_data_i       = req_pending ? word_at(req_addr) : NOP_WORD;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT) begin
      $display("Timeout after %0d cycles, %0d commits still missing",
               cycle_count, unmatched_count());
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    rst_i            = 1'b0;
    mem_data_valid_i = 1'b0;
    mem_data_i       = NOP_WORD;
    dbg_idx_i        = '0;
    value_errors     = 0;
    other_errors     = 0;
    cycle_count      = 0;
    req_pending      = 1'b0;
    req_addr         = '0;
    next_addr        = `CPU_RESET_PC;
    first_req_seen   = 1'b0;
    build_program();

    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b1;

    while (unmatched_count() != 0) begin
      @(posedge clk_i);
    end

    // Architectural state through the debug port, x0 included
    for (int i = 0; i < NREGS; i++) begin
      @(posedge clk_i);
      #1;
      dbg_idx_i = reg_idx_t'(i);
      @(negedge clk_i);
      check_data($sformatf("dbg_data_o[x%0d]", i), dbg_data_o, model_regs[i]);
    end

    for (int i = 0; i < NPROG; i++) begin
      if (prog_tab[i].commits && match_cnt[i] != 1) begin
        report_error($sformatf("entry %0d (x%0d = %h) committed %0d times",
                               i, prog_tab[i].rd, prog_tab[i].value, match_cnt[i]));
      end
    end

    $display("Errors: %0d value mismatches, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/rbank.sv
verilog/alu_stage.sv
verilog/mul_stages.sv
verilog/wb_stage.sv
verilog/cpu.sv
bench/cpu_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module cpu_tb --Mdir obj_dir -o cpu_tb_sim

./obj_dir/cpu_tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation reported errors, see sim.log"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0
